/* common/udp_engine_pkg.sv */
package udp_engine_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] udp_len_t;
  typedef logic [3:0]  csr_addr_t;
  typedef logic [31:0] csr_data_t;

  typedef enum logic {
    HEADER,
    PAYLOAD
  } rx_state_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HEADER,
    TX_PAYLOAD
  } tx_state_e;

  // IP, src port, dst port, length, checksum
  localparam int       FRAME_HDR_BYTES = 12;
  localparam int       HDR_CNT_W       = $clog2(FRAME_HDR_BYTES);
  localparam udp_len_t UDP_HDR_LEN     = 16'd8;

  localparam csr_addr_t REG_CTRL       = 4'd0;
  localparam csr_addr_t REG_STATUS     = 4'd1;
  localparam csr_addr_t REG_SEND_IP    = 4'd2;
  localparam csr_addr_t REG_SEND_PORTS = 4'd3;
  localparam csr_addr_t REG_SEND_LEN   = 4'd4;
  localparam csr_addr_t REG_RECV_IP    = 4'd5;
  localparam csr_addr_t REG_RECV_PORTS = 4'd6;
  localparam csr_addr_t REG_RECV_LEN   = 4'd7;
  localparam csr_addr_t REG_RX_DATA    = 4'd8;
  localparam csr_addr_t REG_TX_DATA    = 4'd9;

  // REG_CTRL trigger bits
  localparam int CTRL_SEND      = 0;
  localparam int CTRL_CLR_IRQ   = 1;
  localparam int CTRL_CLR_RXF   = 2;
  localparam int CTRL_CLR_TXF   = 3;

endpackage

/* logic/pkt_fifo.sv */
`timescale 1ns/10ps

module pkt_fifo #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_clear,
  input  logic                  i_push,
  input  udp_engine_pkg::byte_t i_data,
  input  logic                  i_pop,
  output udp_engine_pkg::byte_t o_data,
  output logic                  o_empty,
  output logic                  o_full
);
  import udp_engine_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);

  byte_t       mem [FIFO_DEPTH];
  logic [AW:0] wr_ptr, rd_ptr;
  logic        do_push, do_pop;

  // Extra MSB tells a full buffer from an empty one
  assign o_empty = (wr_ptr == rd_ptr);
  assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign o_data  = mem[rd_ptr[AW-1:0]];

  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  always_ff @(posedge clk) begin
    if (rst || i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[AW-1:0]] <= i_data;
    end
  end

endmodule

/* logic/udp_csr.sv */
`timescale 1ns/10ps

module udp_csr (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_csr_valid,
  input  logic                      i_csr_write,
  input  udp_engine_pkg::csr_addr_t i_csr_addr,
  input  udp_engine_pkg::csr_data_t i_csr_wdata,
  output logic                      o_csr_rvalid,
  output udp_engine_pkg::csr_data_t o_csr_rdata,
  input  udp_engine_pkg::ip_addr_t  i_recv_ip,
  input  udp_engine_pkg::udp_port_t i_recv_src_port,
  input  udp_engine_pkg::udp_port_t i_recv_dst_port,
  input  udp_engine_pkg::udp_len_t  i_recv_len,
  input  logic                      i_irq_rx,
  input  logic                      i_irq_tx,
  input  logic                      i_send_busy,
  input  udp_engine_pkg::byte_t     i_rx_fifo_data,
  input  logic                      i_rx_fifo_empty,
  input  logic                      i_rx_fifo_full,
  input  logic                      i_tx_fifo_empty,
  input  logic                      i_tx_fifo_full,
  output udp_engine_pkg::ip_addr_t  o_send_ip,
  output udp_engine_pkg::udp_port_t o_send_src_port,
  output udp_engine_pkg::udp_port_t o_send_dst_port,
  output udp_engine_pkg::udp_len_t  o_send_len,
  output logic                      o_send_trig,
  output logic                      o_clear_irq,
  output logic                      o_rx_fifo_clear,
  output logic                      o_tx_fifo_clear,
  output logic                      o_rx_fifo_pop,
  output logic                      o_tx_fifo_push,
  output udp_engine_pkg::byte_t     o_tx_fifo_data
);
  import udp_engine_pkg::*;

  logic      wr_en, rd_en, ctrl_wr;
  csr_data_t rd_mux;

  assign wr_en   = i_csr_valid && i_csr_write;
  assign rd_en   = i_csr_valid && !i_csr_write;
  assign ctrl_wr = wr_en && (i_csr_addr == REG_CTRL);

  // Triggers last exactly one bus cycle
  assign o_send_trig     = ctrl_wr && i_csr_wdata[CTRL_SEND];
  assign o_clear_irq     = ctrl_wr && i_csr_wdata[CTRL_CLR_IRQ];
  assign o_rx_fifo_clear = ctrl_wr && i_csr_wdata[CTRL_CLR_RXF];
  assign o_tx_fifo_clear = ctrl_wr && i_csr_wdata[CTRL_CLR_TXF];

  assign o_rx_fifo_pop  = rd_en && (i_csr_addr == REG_RX_DATA);
  assign o_tx_fifo_push = wr_en && (i_csr_addr == REG_TX_DATA);
  assign o_tx_fifo_data = i_csr_wdata[7:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      o_send_ip       <= '0;
      o_send_src_port <= '0;
      o_send_dst_port <= '0;
      o_send_len      <= '0;
    end else if (wr_en) begin
      case (i_csr_addr)
        REG_SEND_IP:    o_send_ip <= i_csr_wdata;
        REG_SEND_PORTS: begin
          o_send_src_port <= i_csr_wdata[31:16];
          o_send_dst_port <= i_csr_wdata[15:0];
        end
        REG_SEND_LEN:   o_send_len <= i_csr_wdata[15:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_mux = '0;
    case (i_csr_addr)
      REG_STATUS: begin
        rd_mux[6:0] = {i_send_busy, i_tx_fifo_full, i_tx_fifo_empty,
                       i_rx_fifo_full, i_rx_fifo_empty, i_irq_tx, i_irq_rx};
      end
      REG_SEND_IP:    rd_mux = o_send_ip;
      REG_SEND_PORTS: rd_mux = {o_send_src_port, o_send_dst_port};
      REG_SEND_LEN:   rd_mux[15:0] = o_send_len;
      REG_RECV_IP:    rd_mux = i_recv_ip;
      REG_RECV_PORTS: rd_mux = {i_recv_src_port, i_recv_dst_port};
      REG_RECV_LEN:   rd_mux[15:0] = i_recv_len;
      // Empty FIFO reads as zero
      REG_RX_DATA: begin
        if (!i_rx_fifo_empty) begin
          rd_mux[7:0] = i_rx_fifo_data;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_csr_rvalid <= 1'b0;
    end else begin
      o_csr_rvalid <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      o_csr_rdata <= rd_mux;
    end
  end

endmodule

/* logic/udp_ctrl.sv */
`timescale 1ns/10ps

module udp_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_hdr_valid,
  input  udp_engine_pkg::ip_addr_t  i_hdr_ip,
  input  udp_engine_pkg::udp_port_t i_hdr_src_port,
  input  udp_engine_pkg::udp_port_t i_hdr_dst_port,
  input  udp_engine_pkg::udp_len_t  i_hdr_len,
  input  logic                      i_rx_frame_done,
  input  logic                      i_send_trig,
  input  logic                      i_clear_irq,
  input  logic                      i_start_ready,
  input  logic                      i_tx_frame_done,
  output udp_engine_pkg::ip_addr_t  o_recv_ip,
  output udp_engine_pkg::udp_port_t o_recv_src_port,
  output udp_engine_pkg::udp_port_t o_recv_dst_port,
  output udp_engine_pkg::udp_len_t  o_recv_len,
  output logic                      o_start_valid,
  output logic                      o_send_busy,
  output logic                      o_irq_rx,
  output logic                      o_irq_tx
);
  import udp_engine_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_recv_ip       <= '0;
      o_recv_src_port <= '0;
      o_recv_dst_port <= '0;
      o_recv_len      <= '0;
    end else if (i_hdr_valid) begin
      o_recv_ip       <= i_hdr_ip;
      o_recv_src_port <= i_hdr_src_port;
      o_recv_dst_port <= i_hdr_dst_port;
      o_recv_len      <= i_hdr_len;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_start_valid <= 1'b0;
      o_send_busy   <= 1'b0;
      o_irq_rx      <= 1'b0;
      o_irq_tx      <= 1'b0;
    end else begin
      // Request stays pending until the framer is idle
      if (o_start_valid && i_start_ready) begin
        o_start_valid <= 1'b0;
      end
      if (i_send_trig) begin
        o_start_valid <= 1'b1;
      end

      if (i_tx_frame_done) begin
        o_send_busy <= 1'b0;
      end
      if (i_send_trig) begin
        o_send_busy <= 1'b1;
      end

      if (i_rx_frame_done) begin
        o_irq_rx <= 1'b1;
      end
      if (i_tx_frame_done) begin
        o_irq_tx <= 1'b1;
      end
      // Clear beats a set in the same cycle
      if (i_clear_irq) begin
        o_irq_rx <= 1'b0;
        o_irq_tx <= 1'b0;
      end
    end
  end

endmodule

/* rx/udp_rx_parser.sv */
`timescale 1ns/10ps

module udp_rx_parser (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_rx_valid,
  input  udp_engine_pkg::byte_t     i_rx_data,
  input  logic                      i_rx_last,
  input  logic                      i_fifo_full,
  output logic                      o_rx_ready,
  output logic                      o_hdr_valid,
  output udp_engine_pkg::ip_addr_t  o_hdr_ip,
  output udp_engine_pkg::udp_port_t o_hdr_src_port,
  output udp_engine_pkg::udp_port_t o_hdr_dst_port,
  output udp_engine_pkg::udp_len_t  o_hdr_len,
  output logic                      o_fifo_push,
  output udp_engine_pkg::byte_t     o_fifo_data,
  output logic                      o_frame_done
);
  import udp_engine_pkg::*;

  // Checksum bytes are dropped, only IP, ports and length are kept
  localparam int                   FIELD_BYTES = FRAME_HDR_BYTES - 2;
  localparam logic [HDR_CNT_W-1:0] HDR_LAST    = HDR_CNT_W'(FRAME_HDR_BYTES - 1);

  rx_state_e             state;
  logic [HDR_CNT_W-1:0]  hdr_cnt;
  logic [8*FIELD_BYTES-1:0] hdr_sr;
  logic                  rx_en;
  logic                  xfer;

  // Held low for the first cycle out of reset
  assign o_rx_ready = rx_en && ((state == HEADER) || !i_fifo_full);
  assign xfer       = i_rx_valid && o_rx_ready;

  assign o_hdr_valid    = xfer && (state == HEADER) && (hdr_cnt == HDR_LAST);
  assign o_hdr_ip       = hdr_sr[79:48];
  assign o_hdr_src_port = hdr_sr[47:32];
  assign o_hdr_dst_port = hdr_sr[31:16];
  assign o_hdr_len      = hdr_sr[15:0];

  assign o_fifo_push  = xfer && (state == PAYLOAD);
  assign o_fifo_data  = i_rx_data;
  assign o_frame_done = o_fifo_push && i_rx_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_en   <= 1'b0;
      state   <= HEADER;
      hdr_cnt <= '0;
    end else begin
      rx_en <= 1'b1;
      if (xfer) begin
        case (state)
          HEADER: begin
            if (hdr_cnt == HDR_LAST) begin
              hdr_cnt <= '0;
              state   <= PAYLOAD;
            end else begin
              hdr_cnt <= hdr_cnt + 1'b1;
            end
          end
          PAYLOAD: begin
            if (i_rx_last) begin
              state <= HEADER;
            end
          end
          default: state <= HEADER;
        endcase
      end
    end
  end

  // MSB first, so the first byte ends up on top
  always_ff @(posedge clk) begin
    if (xfer && (state == HEADER) && (hdr_cnt < FIELD_BYTES)) begin
      hdr_sr <= {hdr_sr[8*FIELD_BYTES-9:0], i_rx_data};
    end
  end

endmodule

/* tx/udp_tx_framer.sv */
`timescale 1ns/10ps

module udp_tx_framer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_start_valid,
  input  udp_engine_pkg::ip_addr_t  i_send_ip,
  input  udp_engine_pkg::udp_port_t i_send_src_port,
  input  udp_engine_pkg::udp_port_t i_send_dst_port,
  input  udp_engine_pkg::udp_len_t  i_send_len,
  input  udp_engine_pkg::byte_t     i_fifo_data,
  input  logic                      i_fifo_empty,
  input  logic                      i_tx_ready,
  output logic                      o_start_ready,
  output logic                      o_fifo_pop,
  output logic                      o_tx_valid,
  output udp_engine_pkg::byte_t     o_tx_data,
  output logic                      o_tx_last,
  output logic                      o_frame_done
);
  import udp_engine_pkg::*;

  localparam logic [HDR_CNT_W-1:0] HDR_LAST = HDR_CNT_W'(FRAME_HDR_BYTES - 1);

  tx_state_e                    state;
  logic [HDR_CNT_W-1:0]         hdr_cnt;
  logic [8*FRAME_HDR_BYTES-1:0] hdr_sr;
  udp_len_t                     pay_cnt;
  logic                         xfer;

  assign o_start_ready = (state == TX_IDLE);

  always_comb begin
    o_tx_valid = 1'b0;
    o_tx_last  = 1'b0;
    case (state)
      TX_HEADER: begin
        o_tx_valid = 1'b1;
        // Zero-length frame ends on the checksum
        o_tx_last  = (hdr_cnt == HDR_LAST) && (pay_cnt == '0);
      end
      TX_PAYLOAD: begin
        o_tx_valid = !i_fifo_empty;
        o_tx_last  = (pay_cnt == 16'd1);
      end
      default: ;
    endcase
  end

  assign o_tx_data    = (state == TX_PAYLOAD) ? i_fifo_data : hdr_sr[8*FRAME_HDR_BYTES-1 -: 8];
  assign xfer         = o_tx_valid && i_tx_ready;
  assign o_fifo_pop   = xfer && (state == TX_PAYLOAD);
  assign o_frame_done = xfer && o_tx_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= TX_IDLE;
      hdr_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          hdr_cnt <= '0;
          if (i_start_valid) begin
            state <= TX_HEADER;
          end
        end
        TX_HEADER: begin
          if (xfer) begin
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_cnt == HDR_LAST) begin
              state <= (pay_cnt == '0) ? TX_IDLE : TX_PAYLOAD;
            end
          end
        end
        TX_PAYLOAD: begin
          if (xfer && o_tx_last) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Header fields are taken when the start is accepted, checksum left at zero
  always_ff @(posedge clk) begin
    if (o_start_ready && i_start_valid) begin
      hdr_sr  <= {i_send_ip, i_send_src_port, i_send_dst_port,
                  udp_len_t'(i_send_len + UDP_HDR_LEN), 16'h0000};
      pay_cnt <= i_send_len;
    end else if (xfer && (state == TX_HEADER)) begin
      hdr_sr <= {hdr_sr[8*FRAME_HDR_BYTES-9:0], 8'h00};
    end else if (o_fifo_pop) begin
      pay_cnt <= pay_cnt - 1'b1;
    end
  end

endmodule

/* logic/udp_engine.sv */
`timescale 1ns/10ps

module udp_engine #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_csr_valid,
  input  logic                      i_csr_write,
  input  udp_engine_pkg::csr_addr_t i_csr_addr,
  input  udp_engine_pkg::csr_data_t i_csr_wdata,
  output logic                      o_csr_rvalid,
  output udp_engine_pkg::csr_data_t o_csr_rdata,
  input  logic                      i_rx_valid,
  input  udp_engine_pkg::byte_t     i_rx_data,
  input  logic                      i_rx_last,
  output logic                      o_rx_ready,
  output logic                      o_tx_valid,
  output udp_engine_pkg::byte_t     o_tx_data,
  output logic                      o_tx_last,
  input  logic                      i_tx_ready,
  output logic                      o_pkt_recv,
  output logic                      o_pkt_sent
);
  import udp_engine_pkg::*;

  ip_addr_t  recv_ip, send_ip, hdr_ip;
  udp_port_t recv_src_port, recv_dst_port, send_src_port, send_dst_port;
  udp_port_t hdr_src_port, hdr_dst_port;
  udp_len_t  recv_len, send_len, hdr_len;
  logic      hdr_valid, rx_frame_done, tx_frame_done;
  logic      send_trig, clear_irq, send_busy;
  logic      start_valid, start_ready;

  // FIFO side
  logic      rx_fifo_clear, rx_fifo_push, rx_fifo_pop, rx_fifo_empty, rx_fifo_full;
  logic      tx_fifo_clear, tx_fifo_push, tx_fifo_pop, tx_fifo_empty, tx_fifo_full;
  byte_t     rx_fifo_wdata, rx_fifo_rdata, tx_fifo_wdata, tx_fifo_rdata;

  udp_csr u_csr (
    .clk              (clk),
    .rst              (rst),
    .i_csr_valid      (i_csr_valid),
    .i_csr_write      (i_csr_write),
    .i_csr_addr       (i_csr_addr),
    .i_csr_wdata      (i_csr_wdata),
    .o_csr_rvalid     (o_csr_rvalid),
    .o_csr_rdata      (o_csr_rdata),
    .i_recv_ip        (recv_ip),
    .i_recv_src_port  (recv_src_port),
    .i_recv_dst_port  (recv_dst_port),
    .i_recv_len       (recv_len),
    .i_irq_rx         (o_pkt_recv),
    .i_irq_tx         (o_pkt_sent),
    .i_send_busy      (send_busy),
    .i_rx_fifo_data   (rx_fifo_rdata),
    .i_rx_fifo_empty  (rx_fifo_empty),
    .i_rx_fifo_full   (rx_fifo_full),
    .i_tx_fifo_empty  (tx_fifo_empty),
    .i_tx_fifo_full   (tx_fifo_full),
    .o_send_ip        (send_ip),
    .o_send_src_port  (send_src_port),
    .o_send_dst_port  (send_dst_port),
    .o_send_len       (send_len),
    .o_send_trig      (send_trig),
    .o_clear_irq      (clear_irq),
    .o_rx_fifo_clear  (rx_fifo_clear),
    .o_tx_fifo_clear  (tx_fifo_clear),
    .o_rx_fifo_pop    (rx_fifo_pop),
    .o_tx_fifo_push   (tx_fifo_push),
    .o_tx_fifo_data   (tx_fifo_wdata)
  );

  udp_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .i_hdr_valid      (hdr_valid),
    .i_hdr_ip         (hdr_ip),
    .i_hdr_src_port   (hdr_src_port),
    .i_hdr_dst_port   (hdr_dst_port),
    .i_hdr_len        (hdr_len),
    .i_rx_frame_done  (rx_frame_done),
    .i_send_trig      (send_trig),
    .i_clear_irq      (clear_irq),
    .i_start_ready    (start_ready),
    .i_tx_frame_done  (tx_frame_done),
    .o_recv_ip        (recv_ip),
    .o_recv_src_port  (recv_src_port),
    .o_recv_dst_port  (recv_dst_port),
    .o_recv_len       (recv_len),
    .o_start_valid    (start_valid),
    .o_send_busy      (send_busy),
    .o_irq_rx         (o_pkt_recv),
    .o_irq_tx         (o_pkt_sent)
  );

  pkt_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
    .clk     (clk),
    .rst     (rst),
    .i_clear (rx_fifo_clear),
    .i_push  (rx_fifo_push),
    .i_data  (rx_fifo_wdata),
    .i_pop   (rx_fifo_pop),
    .o_data  (rx_fifo_rdata),
    .o_empty (rx_fifo_empty),
    .o_full  (rx_fifo_full)
  );

  pkt_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
    .clk     (clk),
    .rst     (rst),
    .i_clear (tx_fifo_clear),
    .i_push  (tx_fifo_push),
    .i_data  (tx_fifo_wdata),
    .i_pop   (tx_fifo_pop),
    .o_data  (tx_fifo_rdata),
    .o_empty (tx_fifo_empty),
    .o_full  (tx_fifo_full)
  );

  udp_rx_parser u_rx_parser (
    .clk            (clk),
    .rst            (rst),
    .i_rx_valid     (i_rx_valid),
    .i_rx_data      (i_rx_data),
    .i_rx_last      (i_rx_last),
    .i_fifo_full    (rx_fifo_full),
    .o_rx_ready     (o_rx_ready),
    .o_hdr_valid    (hdr_valid),
    .o_hdr_ip       (hdr_ip),
    .o_hdr_src_port (hdr_src_port),
    .o_hdr_dst_port (hdr_dst_port),
    .o_hdr_len      (hdr_len),
    .o_fifo_push    (rx_fifo_push),
    .o_fifo_data    (rx_fifo_wdata),
    .o_frame_done   (rx_frame_done)
  );

  udp_tx_framer u_tx_framer (
    .clk             (clk),
    .rst             (rst),
    .i_start_valid   (start_valid),
    .i_send_ip       (send_ip),
    .i_send_src_port (send_src_port),
    .i_send_dst_port (send_dst_port),
    .i_send_len      (send_len),
    .i_fifo_data     (tx_fifo_rdata),
    .i_fifo_empty    (tx_fifo_empty),
    .i_tx_ready      (i_tx_ready),
    .o_start_ready   (start_ready),
    .o_fifo_pop      (tx_fifo_pop),
    .o_tx_valid      (o_tx_valid),
    .o_tx_data       (o_tx_data),
    .o_tx_last       (o_tx_last),
    .o_frame_done    (tx_frame_done)
  );

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int HALF_PERIOD_NS = 4
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  // 8 ns period
  always #(HALF_PERIOD_NS) o_clk = ~o_clk;

endmodule

/* testbench/udp_engine_assert.sv */
`timescale 1ns/10ps

module udp_engine_assert (
  input logic                  clk,
  input logic                  rst,
  input logic                  i_csr_valid,
  input logic                  i_csr_write,
  input logic                  o_csr_rvalid,
  input logic                  i_tx_ready,
  input logic                  o_tx_valid,
  input udp_engine_pkg::byte_t o_tx_data,
  input logic                  o_pkt_recv,
  input logic                  o_pkt_sent
);

  int fail_cnt = 0;

  // Framer holds its byte under back-pressure
  tx_hold: assert property (@(posedge clk) disable iff (rst)
    (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_data)))
    else begin
      $error("tx byte changed while i_tx_ready was low");
      fail_cnt++;
    end

  irq_reset: assert property (@(posedge clk)
    rst |=> (!o_pkt_recv && !o_pkt_sent))
    else begin
      $error("interrupt output high right after reset");
      fail_cnt++;
    end

  rvalid_lat: assert property (@(posedge clk) disable iff (rst)
    o_csr_rvalid == $past(i_csr_valid && !i_csr_write))
    else begin
      $error("o_csr_rvalid not one cycle after a read");
      fail_cnt++;
    end

endmodule

bind udp_engine udp_engine_assert u_assert (
  .clk          (clk),
  .rst          (rst),
  .i_csr_valid  (i_csr_valid),
  .i_csr_write  (i_csr_write),
  .o_csr_rvalid (o_csr_rvalid),
  .i_tx_ready   (i_tx_ready),
  .o_tx_valid   (o_tx_valid),
  .o_tx_data    (o_tx_data),
  .o_pkt_recv   (o_pkt_recv),
  .o_pkt_sent   (o_pkt_sent)
);

/* testbench/tb_udp_engine.sv */
`timescale 1ns/10ps

module tb_udp_engine;
  import udp_engine_pkg::*;

  localparam int FIFO_DEPTH = 64;
  // Tests take roughly 600 cycles
  localparam int MAX_CYCLES = 4000;

  logic      clk, rst;
  logic      csr_valid, csr_write, csr_rvalid;
  csr_addr_t csr_addr;
  csr_data_t csr_wdata, csr_rdata;
  logic      rx_valid, rx_last, rx_ready;
  byte_t     rx_data, tx_data;
  logic      tx_valid, tx_last, tx_ready;
  logic      pkt_recv, pkt_sent;
  int        cycle_cnt, check_cnt, err_cnt, test_err, test_cnt, assert_seen;

  tb_clk_gen u_clk_gen (.o_clk(clk));

  udp_engine #(.FIFO_DEPTH(FIFO_DEPTH)) UUT (
    .clk          (clk),
    .rst          (rst),
    .i_csr_valid  (csr_valid),
    .i_csr_write  (csr_write),
    .i_csr_addr   (csr_addr),
    .i_csr_wdata  (csr_wdata),
    .o_csr_rvalid (csr_rvalid),
    .o_csr_rdata  (csr_rdata),
    .i_rx_valid   (rx_valid),
    .i_rx_data    (rx_data),
    .i_rx_last    (rx_last),
    .o_rx_ready   (rx_ready),
    .o_tx_valid   (tx_valid),
    .o_tx_data    (tx_data),
    .o_tx_last    (tx_last),
    .i_tx_ready   (tx_ready),
    .o_pkt_recv   (pkt_recv),
    .o_pkt_sent   (pkt_sent)
  );

  task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
    check_cnt++;
    assert (act === exp) else begin
      $display("ERR %0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
      test_err++;
    end
  endtask

  task automatic report_test(input string name);
    // Bound assertion failures count against the running test
    test_err += UUT.u_assert.fail_cnt - assert_seen;
    assert_seen = UUT.u_assert.fail_cnt;
    $display("%s: %0d errors", name, test_err);
    err_cnt += test_err;
    test_err = 0;
    test_cnt++;
  endtask

  task automatic reg_write(input csr_addr_t addr, input csr_data_t data);
    @(negedge clk);
    csr_valid = 1'b1;
    csr_write = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    @(negedge clk);
    csr_valid = 1'b0;
    csr_write = 1'b0;
  endtask

  task automatic reg_read(input csr_addr_t addr, output csr_data_t data);
    @(negedge clk);
    csr_valid = 1'b1;
    csr_write = 1'b0;
    csr_addr  = addr;
    @(negedge clk);
    csr_valid = 1'b0;
    check_cnt++;
    assert (csr_rvalid) else begin
      $display("Read of register %0d got no o_csr_rvalid at %0t", addr, $time);
      test_err++;
    end
    data = csr_rdata;
  endtask

  // Big endian as on the wire
  task automatic add_field(ref byte_t q[$], input logic [31:0] val, input int nbytes);
    for (int i = nbytes - 1; i >= 0; i--) begin
      q.push_back(val[8*i +: 8]);
    end
  endtask

  task automatic make_header(ref byte_t q[$], input logic [31:0] ip, input logic [15:0] src,
                             input logic [15:0] dst, input logic [15:0] len,
                             input logic [15:0] csum);
    add_field(q, ip, 4);
    add_field(q, src, 2);
    add_field(q, dst, 2);
    add_field(q, len, 2);
    add_field(q, csum, 2);
  endtask

  task automatic drive_rx_frame(input byte_t bytes[$]);
    logic moved;
    @(negedge clk);
    for (int i = 0; i < bytes.size(); i++) begin
      rx_valid = 1'b1;
      rx_data  = bytes[i];
      rx_last  = (i == bytes.size() - 1);
      moved    = 1'b0;
      // Ready is settled at the falling edge and holds until the next rise
      while (!moved) begin
        moved = rx_ready;
        @(negedge clk);
      end
    end
    rx_valid = 1'b0;
    rx_last  = 1'b0;
  endtask

  task automatic test_reset_regs;
    csr_data_t rd;
    reg_read(REG_STATUS, rd);
    check_eq("STATUS", rd, 32'h14);
    reg_write(REG_SEND_IP, 32'h0A0B_0C0D);
    reg_write(REG_SEND_PORTS, 32'h1111_2222);
    reg_write(REG_SEND_LEN, 32'h0000_05DC);
    reg_read(REG_SEND_IP, rd);
    check_eq("SEND_IP", rd, 32'h0A0B_0C0D);
    reg_read(REG_SEND_PORTS, rd);
    check_eq("SEND_PORTS", rd, 32'h1111_2222);
    reg_read(REG_SEND_LEN, rd);
    check_eq("SEND_LEN", rd, 32'h0000_05DC);
    report_test("reset and registers");
  endtask

  task automatic test_receive;
    byte_t     frame[$];
    byte_t     payload[$];
    csr_data_t rd;
    check_eq("o_pkt_recv", pkt_recv, 1'b0);
    make_header(frame, 32'hC0A8_0105, 16'h1F90, 16'h0035, 16'd28, 16'hBEEF);
    repeat (20) payload.push_back(byte_t'($urandom));
    foreach (payload[i]) frame.push_back(payload[i]);
    drive_rx_frame(frame);
    while (!pkt_recv) begin
      @(negedge clk);
    end
    reg_read(REG_RECV_IP, rd);
    check_eq("RECV_IP", rd, 32'hC0A8_0105);
    reg_read(REG_RECV_PORTS, rd);
    check_eq("RECV_PORTS", rd, 32'h1F90_0035);
    reg_read(REG_RECV_LEN, rd);
    check_eq("RECV_LEN", rd, 32'd28);
    foreach (payload[i]) begin
      reg_read(REG_RX_DATA, rd);
      check_eq("RX_DATA", rd, {24'h0, payload[i]});
    end
    reg_read(REG_STATUS, rd);
    check_eq("STATUS.rx_empty", rd[2], 1'b1);
    reg_read(REG_RX_DATA, rd);
    check_eq("RX_DATA(empty)", rd, 32'h0);
    report_test("receive");
  endtask

  task automatic test_transmit;
    byte_t     exp[$];
    byte_t     payload[$];
    byte_t     got[$];
    logic      lasts[$];
    csr_data_t rd;
    repeat (16) payload.push_back(byte_t'($urandom));
    foreach (payload[i]) reg_write(REG_TX_DATA, {24'h0, payload[i]});
    reg_write(REG_SEND_IP, 32'hC0A8_0001);
    reg_write(REG_SEND_PORTS, 32'h04D2_162E);
    reg_write(REG_SEND_LEN, 32'd16);
    make_header(exp, 32'hC0A8_0001, 16'h04D2, 16'h162E, 16'd24, 16'h0000);
    foreach (payload[i]) exp.push_back(payload[i]);
    check_eq("o_pkt_sent", pkt_sent, 1'b0);
    reg_write(REG_CTRL, 32'h1);
    while (got.size() < exp.size()) begin
      @(negedge clk);
      tx_ready = (($urandom % 3) != 0);
      if (tx_valid && tx_ready) begin
        got.push_back(tx_data);
        lasts.push_back(tx_last);
      end
    end
    @(negedge clk);
    tx_ready = 1'b0;
    foreach (exp[i]) begin
      check_eq($sformatf("o_tx_data[%0d]", i), got[i], exp[i]);
      check_eq($sformatf("o_tx_last[%0d]", i), lasts[i], (i == exp.size() - 1));
    end
    while (!pkt_sent) begin
      @(negedge clk);
    end
    reg_read(REG_STATUS, rd);
    check_eq("STATUS", rd, 32'h17);
    report_test("transmit with back-pressure");
  endtask

  task automatic test_rx_backpressure;
    byte_t     frame[$];
    byte_t     payload[$];
    csr_data_t rd;
    csr_data_t status;
    make_header(frame, 32'h0A00_0001, 16'h1234, 16'h5678, 16'(FIFO_DEPTH + 16), 16'h0);
    repeat (FIFO_DEPTH + 8) payload.push_back(byte_t'($urandom));
    foreach (payload[i]) frame.push_back(payload[i]);
    fork
      drive_rx_frame(frame);
      begin
        status = '0;
        while (!status[3]) begin
          reg_read(REG_STATUS, status);
        end
        check_eq("o_rx_ready", rx_ready, 1'b0);
        for (int i = 0; i < 8; i++) begin
          reg_read(REG_RX_DATA, rd);
          check_eq("RX_DATA", rd, {24'h0, payload[i]});
        end
      end
    join
    for (int i = 8; i < payload.size(); i++) begin
      reg_read(REG_RX_DATA, rd);
      check_eq("RX_DATA", rd, {24'h0, payload[i]});
    end
    reg_read(REG_STATUS, rd);
    check_eq("STATUS", rd, 32'h17);
    report_test("receive back-pressure");
  endtask

  task automatic test_clears;
    byte_t     frame[$];
    csr_data_t rd;
    repeat (3) reg_write(REG_TX_DATA, $urandom);
    make_header(frame, 32'h0A00_0002, 16'h0007, 16'h0009, 16'd12, 16'h0);
    repeat (4) frame.push_back(byte_t'($urandom));
    drive_rx_frame(frame);
    reg_read(REG_STATUS, rd);
    check_eq("STATUS", rd, 32'h03);
    reg_write(REG_CTRL, 32'hC);
    reg_read(REG_STATUS, rd);
    check_eq("STATUS", rd, 32'h17);
    check_eq("o_pkt_recv", pkt_recv, 1'b1);
    check_eq("o_pkt_sent", pkt_sent, 1'b1);
    reg_write(REG_CTRL, 32'h2);
    check_eq("o_pkt_recv", pkt_recv, 1'b0);
    check_eq("o_pkt_sent", pkt_sent, 1'b0);
    reg_read(REG_STATUS, rd);
    check_eq("STATUS", rd, 32'h14);
    report_test("clears");
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    void'($urandom(9611));
    rst         = 1'b1;
    csr_valid   = 1'b0;
    csr_write   = 1'b0;
    csr_addr    = '0;
    csr_wdata   = '0;
    rx_valid    = 1'b0;
    rx_data     = '0;
    rx_last     = 1'b0;
    tx_ready    = 1'b0;
    check_cnt   = 0;
    err_cnt     = 0;
    test_err    = 0;
    test_cnt    = 0;
    assert_seen = 0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    test_reset_regs();
    test_receive();
    test_transmit();
    test_rx_backpressure();
    test_clears();

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* udp_engine.f */
common/udp_engine_pkg.sv
logic/pkt_fifo.sv
logic/udp_csr.sv
logic/udp_ctrl.sv
rx/udp_rx_parser.sv
tx/udp_tx_framer.sv
logic/udp_engine.sv
testbench/tb_clk_gen.sv
testbench/udp_engine_assert.sv
testbench/tb_udp_engine.sv
